/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_ADDI = 6'h06,
        OP_LUI  = 6'h07,
        OP_BEQ  = 6'h08,
        OP_BNE  = 6'h09
    } opcode_t;

    // Single format. rk is imm[15:11].
    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rj;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_decode_pass_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    inst;
        opcode_t  opcode;
        reg_idx_t rd;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;      // Sign-extended.
    } decode_execute_pass_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    inst;
        logic     we;
        reg_idx_t rd;
        word_t    result;
    } execute_writeback_pass_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } forward_req_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_req_t;

    // Trace record of one retired instruction.
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        logic     we;
        reg_idx_t wnum;
        word_t    wdata;
    } retire_t;

endpackage

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rj,
    input  reg_idx_t rk,
    output word_t    rj_data,
    output word_t    rk_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    rd_data
);

    word_t regs [32];
    logic  wr_live;

    assign wr_live = we && (rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd] <= rd_data;
        end
    end

    // Same-cycle write wins over the stored word.
    assign rj_data = (rj == '0) ? '0 : (wr_live && rd == rj) ? rd_data : regs[rj];
    assign rk_data = (rk == '0) ? '0 : (wr_live && rd == rk) ? rd_data : regs[rk];

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  redirect_req_t      redirect,
    input  logic               flush,
    input  logic               next_rdy,
    output logic               imem_req,
    output word_t              imem_addr,
    input  logic               imem_valid,
    input  word_t              imem_data,
    output fetch_decode_pass_t pass_out
);

    logic  running;     // Low until the first edge out of reset.
    logic  pending;     // One request in flight.
    logic  drop;        // Its response is stale.
    logic  held_valid;
    word_t held_inst;
    word_t pc_q;
    word_t next_pc;
    logic  resp_ok;
    logic  accept;
    logic  slot_free;

    assign resp_ok   = imem_valid && pending && !drop;
    assign accept    = pass_out.valid && next_rdy;
    assign slot_free = !(held_valid || resp_ok) || accept || flush;

    assign pass_out.valid = (held_valid || resp_ok) && !flush;
    assign pass_out.pc    = pc_q;
    assign pass_out.inst  = held_valid ? held_inst : imem_data;

    assign next_pc   = redirect.valid ? redirect.target : accept ? pc_q + 32'd4 : pc_q;
    assign imem_addr = next_pc;
    assign imem_req  = running && (!pending || imem_valid) && slot_free;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running    <= 1'b0;
            pending    <= 1'b0;
            drop       <= 1'b0;
            held_valid <= 1'b0;
            pc_q       <= reset_pc;
        end else begin
            running    <= 1'b1;
            pc_q       <= next_pc;
            held_valid <= pass_out.valid && !next_rdy;
            if (imem_req) begin
                pending <= 1'b1;
            end else if (imem_valid) begin
                pending <= 1'b0;
            end
            if (imem_req || imem_valid) begin
                drop <= 1'b0;
            end else if (redirect.valid && pending) begin
                drop <= 1'b1;   // Old response still owed.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_ok) begin
            held_inst <= imem_data;
        end
    end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 next_rdy,
    output logic                 rdy,
    input  fetch_decode_pass_t   pass_in,
    output reg_idx_t             rj,
    output reg_idx_t             rk,
    input  word_t                rj_data,
    input  word_t                rk_data,
    input  forward_req_t         ex_fwd,
    input  forward_req_t         wb_fwd,
    output decode_execute_pass_t pass_out
);

    fetch_decode_pass_t in_q;
    instr_t             inst;
    opcode_t            op;

    assign rdy = !in_q.valid || next_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_q.valid <= 1'b0;
        end else if (flush) begin
            in_q.valid <= 1'b0;
        end else if (rdy) begin
            in_q <= pass_in;
        end
    end

    // ******************************
    // Fields and operands
    // ******************************

    assign inst = instr_t'(in_q.inst);
    assign rj   = inst.rj;
    assign rk   = inst.imm[15:11];

    always_comb begin
        case (inst.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_ADDI, OP_LUI, OP_BEQ, OP_BNE: op = inst.opcode;
            default:                         op = OP_NOP;
        endcase
    end

    // Younger producer first.
    function automatic word_t select_operand(input reg_idx_t idx, input word_t rf_data,
                                             input forward_req_t ex, input forward_req_t wb);
        word_t value;
        if (ex.valid && ex.rd == idx) begin
            value = ex.data;
        end else if (wb.valid && wb.rd == idx) begin
            value = wb.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    assign pass_out.valid  = in_q.valid && !flush;  // Wrong-path slot dies here.
    assign pass_out.pc     = in_q.pc;
    assign pass_out.inst   = in_q.inst;
    assign pass_out.opcode = op;
    assign pass_out.rd     = inst.rd;
    assign pass_out.op_a   = select_operand(rj, rj_data, ex_fwd, wb_fwd);
    assign pass_out.op_b   = select_operand(rk, rk_data, ex_fwd, wb_fwd);
    assign pass_out.imm    = {{16{inst.imm[15]}}, inst.imm};

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    next_rdy,
    output logic                    rdy,
    input  decode_execute_pass_t    pass_in,
    output forward_req_t            fwd,
    output redirect_req_t           redirect,
    output execute_writeback_pass_t pass_out
);

    decode_execute_pass_t in_q;
    word_t                result;
    logic                 writes;
    logic                 we;
    logic                 taken;

    assign rdy = !in_q.valid || next_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_q.valid <= 1'b0;
        end else if (rdy) begin
            in_q <= pass_in;
        end
    end

    // ******************************
    // ALU and branch
    // ******************************

    always_comb begin
        case (in_q.opcode)
            OP_ADD:  result = in_q.op_a + in_q.op_b;
            OP_SUB:  result = in_q.op_a - in_q.op_b;
            OP_AND:  result = in_q.op_a & in_q.op_b;
            OP_OR:   result = in_q.op_a | in_q.op_b;
            OP_XOR:  result = in_q.op_a ^ in_q.op_b;
            OP_ADDI: result = in_q.op_a + in_q.imm;
            OP_LUI:  result = {in_q.imm[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign writes = in_q.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI};
    assign we     = writes && (in_q.rd != '0);   // r0 never written.

    assign taken = (in_q.opcode == OP_BEQ && in_q.op_a == in_q.op_b)
                || (in_q.opcode == OP_BNE && in_q.op_a != in_q.op_b);

    // One pulse per branch, on the cycle it moves on.
    assign redirect.valid  = in_q.valid && taken && next_rdy;
    assign redirect.target = in_q.pc + {in_q.imm[29:0], 2'b00};

    assign fwd.valid = in_q.valid && we;
    assign fwd.rd    = in_q.rd;
    assign fwd.data  = result;

    assign pass_out.valid  = in_q.valid;
    assign pass_out.pc     = in_q.pc;
    assign pass_out.inst   = in_q.inst;
    assign pass_out.we     = we;
    assign pass_out.rd     = in_q.rd;
    assign pass_out.result = result;

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_stage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    rdy,
    input  execute_writeback_pass_t pass_in,
    output logic                    reg_we,
    output reg_idx_t                reg_rd,
    output word_t                   reg_data,
    output forward_req_t            fwd,
    output logic                    retire_valid,
    output retire_t                 retire
);

    execute_writeback_pass_t in_q;

    assign rdy = 1'b1;  // Last stage always drains.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_q.valid <= 1'b0;
        end else if (rdy) begin
            in_q <= pass_in;
        end
    end

    assign reg_we   = in_q.valid && in_q.we && (in_q.rd != '0);
    assign reg_rd   = in_q.rd;
    assign reg_data = in_q.result;

    assign fwd.valid = reg_we;
    assign fwd.rd    = in_q.rd;
    assign fwd.data  = in_q.result;

    // Trace.
    assign retire_valid = in_q.valid;
    assign retire.pc    = in_q.pc;
    assign retire.inst  = in_q.inst;
    assign retire.we    = reg_we;
    assign retire.wnum  = in_q.rd;
    assign retire.wdata = in_q.result;

endmodule

`default_nettype wire

/* design/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top import core_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic    clk,
    input  logic    rst_n,
    output logic    imem_req,
    output word_t   imem_addr,
    input  logic    imem_valid,
    input  word_t   imem_data,
    output logic    retire_valid,
    output retire_t retire
);

    fetch_decode_pass_t      pass_if;
    decode_execute_pass_t    pass_id;
    execute_writeback_pass_t pass_ex;

    logic id_rdy, ex_rdy, wb_rdy;
    logic flush_if, flush_id;

    forward_req_t  ex_fwd, wb_fwd;
    redirect_req_t redirect;

    reg_idx_t rj, rk, rd;
    word_t    rj_data, rk_data, rd_data;
    logic     reg_we;

    // Branch miss kills everything younger than execute.
    assign flush_if = redirect.valid;
    assign flush_id = redirect.valid;

    reg_file u_reg_file (
        .clk, .rst_n,
        .rj, .rk, .rj_data, .rk_data,
        .we(reg_we), .rd, .rd_data
    );

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk, .rst_n,
        .redirect,
        .flush(flush_if),
        .next_rdy(id_rdy),
        .imem_req, .imem_addr, .imem_valid, .imem_data,
        .pass_out(pass_if)
    );

    decode_stage u_decode (
        .clk, .rst_n,
        .flush(flush_id),
        .next_rdy(ex_rdy),
        .rdy(id_rdy),
        .pass_in(pass_if),
        .rj, .rk, .rj_data, .rk_data,
        .ex_fwd, .wb_fwd,
        .pass_out(pass_id)
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .next_rdy(wb_rdy),
        .rdy(ex_rdy),
        .pass_in(pass_id),
        .fwd(ex_fwd),
        .redirect,
        .pass_out(pass_ex)
    );

    writeback_stage u_writeback (
        .clk, .rst_n,
        .rdy(wb_rdy),
        .pass_in(pass_ex),
        .reg_we, .reg_rd(rd), .reg_data(rd_data),
        .fwd(wb_fwd),
        .retire_valid, .retire
    );

endmodule

`default_nettype wire

/* testbench/core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int WAIT_LIMIT = 100;   // Cycles per wait.

    logic    clk;
    logic    rst_n;
    logic    imem_req;
    word_t   imem_addr;
    logic    imem_valid;
    word_t   imem_data;
    logic    retire_valid;
    retire_t retire;

    word_t   mem [word_t];
    retire_t exp_q [$];
    string   name_q [$];
    int      pass_count = 0;
    int      err_count = 0;
    bit      busy = 1'b0;
    int      cnt = 0;
    word_t   req_addr = '0;

    core_top #(.reset_pc(32'h0)) dut (
        .clk, .rst_n,
        .imem_req, .imem_addr, .imem_valid, .imem_data,
        .retire_valid, .retire
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic word_t read_imem(input word_t addr);
        return mem.exists(addr) ? mem[addr] : 32'h0;   // Unloaded reads as NOP.
    endfunction

    // ******************************
    // Instruction memory model
    // ******************************

    always @(posedge clk) begin
        if (!rst_n) begin
            imem_valid <= 1'b0;
            busy = 1'b0;
        end else begin
            imem_valid <= 1'b0;
            if (busy) begin
                cnt--;
                if (cnt == 0) begin
                    imem_valid <= 1'b1;
                    imem_data  <= read_imem(req_addr);
                    busy = 1'b0;
                end
            end
            if (imem_req) begin
                req_addr = imem_addr;
                cnt = int'($urandom % 4);   // Latency minus one.
                if (cnt == 0) begin
                    imem_valid <= 1'b1;
                    imem_data  <= read_imem(req_addr);
                end else begin
                    busy = 1'b1;
                end
            end
        end
    end

    function automatic string format_retire(input retire_t r);
        return $sformatf("pc=%h inst=%h we=%b wnum=%0d wdata=%h",
                         r.pc, r.inst, r.we, r.wnum, r.wdata);
    endfunction

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        if (act !== exp) begin
            err_count++;
            $display("Error: %s expected %s, actual %s",
                     name, format_retire(exp), format_retire(act));
        end else begin
            pass_count++;
            $display("Pass: %s", name);
        end
    endtask

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            err_count++;
            $display("Error: %s expected %h, actual %h", name, exp, act);
        end else begin
            pass_count++;
            $display("Pass: %s", name);
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          waited;
        string       line;
        string       e_name;
        word_t       a, w, e_pc, e_inst, e_wdata;
        int          e_we, e_wnum;
        retire_t     rec;
        bit          seen;
        bit          quiet;
        bit          aborted;

        void'($urandom(32'h4361_a715));
        rst_n      <= 1'b0;
        imem_valid <= 1'b0;
        imem_data  <= '0;
        aborted    = 1'b0;
        quiet      = 1'b1;

        fd = $fopen("testbench/prog_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            err_count++;
            aborted = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 2) continue;
                if (line.substr(0, 0) == "P") begin
                    n = $sscanf(line, "P %h %h", a, w);
                    mem[a] = w;
                end else if (line.substr(0, 0) == "E") begin
                    n = $sscanf(line, "E %h %h %h %h %h %s",
                                e_pc, e_inst, e_we, e_wnum, e_wdata, e_name);
                    rec.pc    = e_pc;
                    rec.inst  = e_inst;
                    rec.we    = e_we[0];
                    rec.wnum  = e_wnum[4:0];
                    rec.wdata = e_wdata;
                    exp_q.push_back(rec);
                    name_q.push_back(e_name);
                end
            end
            $fclose(fd);
        end

        // No request and no retire while in reset.
        repeat (16) begin
            @(negedge clk);
            if (retire_valid !== 1'b0 || imem_req !== 1'b0) quiet = 1'b0;
        end
        if (quiet) begin
            pass_count++;
            $display("Pass: reset_quiet");
        end else begin
            err_count++;
            $display("Request or retire seen while reset was asserted");
        end
        @(posedge clk);
        rst_n <= 1'b1;

        seen   = 1'b0;
        waited = 0;
        while (!aborted && !seen && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (imem_req) seen = 1'b1;
            else waited++;
        end
        if (!aborted && !seen) begin
            $display("No instruction request came after reset");
            err_count++;
            aborted = 1'b1;
        end else if (!aborted) begin
            check_addr("first_fetch", 32'h0, imem_addr);
        end

        for (int i = 0; i < exp_q.size() && !aborted; i++) begin
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < WAIT_LIMIT) begin
                @(negedge clk);
                if (retire_valid) seen = 1'b1;
                else waited++;
            end
            if (!seen) begin
                $display("No instruction retired in time for test %s", name_q[i]);
                err_count++;
                aborted = 1'b1;
            end else begin
                check_retire(name_q[i], exp_q[i], retire);
            end
        end

        $display("Tests: %0d passed, %0d errors", pass_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/core_pkg.sv
design/reg_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/core_top.sv
testbench/core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = core_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(wildcard design/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/prog_stim.txt */
# P <byte address> <instruction word>
# E <pc> <inst> <we> <wnum> <wdata> <test name>, in retire order
P 00000000 18200005
P 00000004 1840FFFD
P 00000008 04611000
P 0000000C 08830800
P 00000010 0CA40800
P 00000014 10C51000
P 00000018 14E60800
P 0000001C 1D001234
P 00000020 18010007
P 00000024 05200800
P 00000028 24010003
P 0000002C 19400077
P 00000030 19600088
P 00000034 20010005
P 00000038 19830001
P 0000003C 20000003
P 00000040 19A00001
P 00000044 19C00002
P 00000048 FDE00000
P 0000004C 05EC4800
P 00000050 1A0FFFFF
E 00000000 18200005 1 01 00000005 addi_pos
E 00000004 1840FFFD 1 02 FFFFFFFD addi_neg
E 00000008 04611000 1 03 00000002 add_fwd
E 0000000C 08830800 1 04 FFFFFFFD sub_fwd
E 00000010 0CA40800 1 05 00000005 and_fwd
E 00000014 10C51000 1 06 FFFFFFFD or_fwd
E 00000018 14E60800 1 07 FFFFFFF8 xor_fwd
E 0000001C 1D001234 1 08 12340000 lui
E 00000020 18010007 0 00 0000000C r0_write
E 00000024 05200800 1 09 00000005 r0_read
E 00000028 24010003 0 00 00000000 bne_taken
E 00000034 20010005 0 00 00000000 beq_not_taken
E 00000038 19830001 1 0C 00000003 after_not_taken
E 0000003C 20000003 0 00 00000000 beq_taken
E 00000048 FDE00000 0 0F 00000000 unknown_nop
E 0000004C 05EC4800 1 0F 00000008 add_at_target
E 00000050 1A0FFFFF 1 10 00000007 addi_dep
